// ==== files.f ====
+incdir+dv
common/mac_pkg.sv
hw/mac_core/mul_line.sv
hw/mac_core/adder_tree.sv
hw/mac_core/mac_core.sv
dv/tb_mac_core.sv

// ==== Makefile ====
# Verilator simulation of the dot-product engine
# Any variable below can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_mac_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= all tests passed

SIM_BIN := ./$(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

# Build, run, then decide from the log
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/mac_vectors.svh ====
`ifndef MAC_VECTORS_SVH
`define MAC_VECTORS_SVH

// Each row gives idata_a, idata_b, valid, the count of random words that follow and the sum
// Lane 0 is the low byte
// Expected sums on idle rows are never used

task automatic load_vectors();
    // Idle bus after reset with junk that must not leak out
    add_row(64'h0000_0000_0000_0000, 64'h0000_0000_0000_0000, 1'b0, 0, 0);
    add_row(64'h1111_1111_1111_1111, 64'h2222_2222_2222_2222, 1'b0, 0, 0);

    // Zeros
    add_row(64'h0000_0000_0000_0000, 64'h0000_0000_0000_0000, 1'b1, 0, 0);
    add_row(64'h3333_3333_3333_3333, 64'h4444_4444_4444_4444, 1'b0, 0, 0);

    // Largest positive sum from all lanes at -128 by -128
    add_row(64'h8080_8080_8080_8080, 64'h8080_8080_8080_8080, 1'b1, 0, 131072);
    add_row(64'h0000_0000_0000_0000, 64'h0000_0000_0000_0000, 1'b0, 0, 0);
    add_row(64'h7f7f_7f7f_7f7f_7f7f, 64'h7f7f_7f7f_7f7f_7f7f, 1'b0, 0, 0);
    add_row(64'h0000_0000_0000_0000, 64'h0000_0000_0000_0000, 1'b0, 0, 0);

    // Isolated word with the most negative sum
    add_row(64'h8080_8080_8080_8080, 64'h7f7f_7f7f_7f7f_7f7f, 1'b1, 0, -130048);
    add_row(64'h0000_0000_0000_0000, 64'h0000_0000_0000_0000, 1'b0, 0, 0);
    add_row(64'h5555_5555_5555_5555, 64'h0101_0101_0101_0101, 1'b0, 0, 0);
    add_row(64'h0000_0000_0000_0000, 64'h0000_0000_0000_0000, 1'b0, 0, 0);
    add_row(64'h0000_0000_0000_0000, 64'h0000_0000_0000_0000, 1'b0, 0, 0);

    // Back-to-back words running into a random burst
    add_row(64'h0101_0101_0101_0101, 64'h0101_0101_0101_0101, 1'b1, 0, 8);
    add_row(64'h0807_0605_0403_0201, 64'hffff_ffff_ffff_ffff, 1'b1, 0, -36);
    add_row(64'h7f7f_7f7f_7f7f_7f7f, 64'h7f7f_7f7f_7f7f_7f7f, 1'b1, 60, 129032);
    add_row(64'h0000_0000_0000_0000, 64'h0000_0000_0000_0000, 1'b0, 0, 0);

    // Low half negative ones against mixed lanes
    add_row(64'h0000_0000_ffff_ffff, 64'h1122_3344_5566_7788, 1'b1, 0, -186);
    add_row(64'h0000_0000_0000_0000, 64'h0000_0000_0000_0000, 1'b0, 0, 0);
    add_row(64'h0000_0000_0000_0000, 64'h0000_0000_0000_0000, 1'b0, 0, 0);

    // Single lane at each end of the word
    add_row(64'h0000_0000_0000_0080, 64'h0000_0000_0000_0081, 1'b1, 80, 16256);
    add_row(64'h0000_0000_0000_0000, 64'h0000_0000_0000_0000, 1'b0, 0, 0);
    add_row(64'h9c00_0000_0000_0000, 64'h6400_0000_0000_0000, 1'b1, 0, -10000);
    add_row(64'h0000_0000_0000_0000, 64'h0000_0000_0000_0000, 1'b0, 0, 0);
    add_row(64'h2222_2222_2222_2222, 64'h3333_3333_3333_3333, 1'b0, 0, 0);
    add_row(64'h0000_0000_0000_0000, 64'h0000_0000_0000_0000, 1'b0, 0, 0);

    // Alternating signs followed by the last random burst
    add_row(64'hff01_ff01_ff01_ff01, 64'h7f80_7f80_7f80_7f80, 1'b1, 60, -1020);
    add_row(64'h0000_0000_0000_0000, 64'h0000_0000_0000_0000, 1'b0, 0, 0);
endtask

`endif

// ==== dv/tb_mac_core.sv ====
`default_nettype none

module tb_mac_core
    import mac_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 10;

    logic      clk;
    logic      rstn;
    lane_vec_t idata_a;
    lane_vec_t idata_b;
    logic      idata_valid;
    sum_t      odata;
    logic      odata_valid;

    // Stimulus table filled by load_vectors
    lane_vec_t row_a[$];
    lane_vec_t row_b[$];
    logic      row_valid[$];
    int        row_rand[$];
    sum_t      row_exp[$];

    // Results still in flight with the oldest first
    sum_t exp_q[$];

    // Expected odata_valid with one bit per pipeline cycle
    logic [CORE_LAT-1:0] valid_pipe;

    integer seed;
    int     in_cnt;
    int     out_cnt;
    int     cycle_cnt;
    int     cycle_limit;

    mac_core dut_i (
        .clk         (clk),
        .rstn        (rstn),
        .idata_a     (idata_a),
        .idata_b     (idata_b),
        .idata_valid (idata_valid),
        .odata       (odata),
        .odata_valid (odata_valid)
    );

    `include "mac_vectors.svh"

    // ==================================================
    // Helpers
    // ==================================================

    task automatic add_row(
        input lane_vec_t a,
        input lane_vec_t b,
        input logic      valid,
        input int        rand_num,
        input int        exp_sum
    );
        row_a.push_back(a);
        row_b.push_back(b);
        row_valid.push_back(valid);
        row_rand.push_back(rand_num);
        row_exp.push_back(sum_t'(exp_sum));
    endtask

    // Signed sum over all lanes of the lane products
    function automatic sum_t dot_model(lane_vec_t a, lane_vec_t b);
        lane_t la;
        lane_t lb;
        int    acc;
        acc = 0;
        for (int i = 0; i < MAC_NUM; i++) begin
            la = a[i*IDATA_BIT +: IDATA_BIT];
            lb = b[i*IDATA_BIT +: IDATA_BIT];
            acc += int'(la) * int'(lb);
        end
        return sum_t'(acc);
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_sum(input sum_t exp_sum);
        if (odata !== exp_sum) begin
            report_failure($sformatf("mismatch at %0t: odata expected %0d, got %0d",
                                     $time, exp_sum, odata));
        end
    endtask

    task automatic check_valid(input logic exp_valid);
        if (odata_valid !== exp_valid) begin
            report_failure($sformatf("mismatch at %0t: odata_valid expected %0b, got %0b",
                                     $time, exp_valid, odata_valid));
        end
    endtask

    // Called just after a falling edge
    task automatic drive_word(
        input lane_vec_t a,
        input lane_vec_t b,
        input logic      valid,
        input sum_t      exp_sum
    );
        idata_a     = a;
        idata_b     = b;
        idata_valid = valid;
        if (valid) begin
            exp_q.push_back(exp_sum);
            in_cnt++;
        end
    endtask

    // ==================================================
    // Clock and timeout
    // ==================================================

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        wait (rstn === 1'b1);
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (cycle_cnt > cycle_limit) begin
                report_failure($sformatf("timeout: run still busy after %0d cycles",
                                         cycle_cnt));
            end
        end
    end

    // ==================================================
    // Output checking
    // ==================================================

    always @(posedge clk) begin
        if (!rstn) begin
            valid_pipe = '0;
        end else begin
            check_valid(valid_pipe[CORE_LAT-1]);
            if (odata_valid) begin
                if (exp_q.size() == 0) begin
                    report_failure("odata_valid went high with no input word in flight");
                end else begin
                    check_sum(exp_q.pop_front());
                    out_cnt++;
                end
            end
            valid_pipe = {valid_pipe[CORE_LAT-2:0], idata_valid};
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================

    initial begin
        lane_vec_t a;
        lane_vec_t b;
        int        rand_total;

        seed        = 32'h7b91_0d4c;
        rstn        = 1'b0;
        idata_a     = '0;
        idata_b     = '0;
        idata_valid = 1'b0;
        in_cnt      = 0;
        out_cnt     = 0;
        rand_total  = 0;

        load_vectors();
        foreach (row_rand[r]) begin
            rand_total += row_rand[r];
        end
        cycle_limit = row_a.size() + rand_total + CORE_LAT + 20;

        repeat (RESET_CYCLES) @(negedge clk);
        rstn = 1'b1;

        for (int r = 0; r < row_a.size(); r++) begin
            @(negedge clk);
            drive_word(row_a[r], row_b[r], row_valid[r], row_exp[r]);
            // Random words follow this row back to back
            for (int k = 0; k < row_rand[r]; k++) begin
                a = {$random(seed), $random(seed)};
                b = {$random(seed), $random(seed)};
                @(negedge clk);
                drive_word(a, b, 1'b1, dot_model(a, b));
            end
        end

        @(negedge clk);
        idata_valid = 1'b0;
        // Last word drains in CORE_LAT cycles and the idle output stays watched
        repeat (CORE_LAT + 2) @(negedge clk);

        if (out_cnt != in_cnt) begin
            report_failure($sformatf("got %0d results for %0d input words",
                                     out_cnt, in_cnt));
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mac_core/mac_core.sv ====
`default_nettype none

// ==================================================
// Dot-product engine top
// ==================================================
// Eight signed byte lanes per bus word, multiplied in
// pairs and summed. Result appears CORE_LAT cycles after
// the sampling edge, in input order.

module mac_core
    import mac_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rstn,

    // Operand words and their strobe
    input  wire lane_vec_t idata_a,
    input  wire lane_vec_t idata_b,
    input  wire logic      idata_valid,

    // Signed dot product
    output sum_t           odata,
    output logic           odata_valid
);

    // Multiplier line to adder tree
    prod_vec_t product;
    logic      product_valid;

    // One-cycle multiplier stage
    mul_line mul_line_i (
        .clk           (clk),
        .rstn          (rstn),
        .idata_a       (idata_a),
        .idata_b       (idata_b),
        .idata_valid   (idata_valid),
        .product       (product),
        .product_valid (product_valid)
    );

    // TREE_LAT-cycle reduction
    adder_tree adder_tree_i (
        .clk           (clk),
        .rstn          (rstn),
        .product       (product),
        .product_valid (product_valid),
        .odata         (odata),
        .odata_valid   (odata_valid)
    );

endmodule

`default_nettype wire

// ==== hw/mac_core/adder_tree.sv ====
`default_nettype none

// ==================================================
// Signed adder tree
// ==================================================
// STAGE_NUM levels, each one halving the operand count
// and growing the sum by one bit.
// Stage 0 and even stages register their operands.
// Odd stages add straight through.
// The valid chain uses the same register pattern so it
// stays aligned with the data.

module adder_tree
    import mac_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rstn,

    // Lane products from the multiplier line
    input  wire prod_vec_t product,
    input  wire logic      product_valid,

    // Final sum and its strobe
    output sum_t           odata,
    output logic           odata_valid
);

    for (genvar s = 0; s < STAGE_NUM; s++) begin : gen_stage

        // Operand and result widths at this level
        localparam int IN_BIT  = PROD_BIT + s;
        localparam int OUT_BIT = IN_BIT + 1;

        // Number of adders at this level
        localparam int OUT_NUM = MAC_NUM >> (s + 1);

        // Operands entering this level
        logic [2*OUT_NUM*IN_BIT-1:0] in_vec;
        logic                        in_valid;

        // Sums leaving this level
        logic [OUT_NUM*OUT_BIT-1:0]  sum_vec;
        logic                        stage_valid;

        // ==================================================
        // Level input selection
        // ==================================================

        if (s == 0) begin : gen_src_top
            assign in_vec   = product;
            assign in_valid = product_valid;
        end else begin : gen_src_prev
            assign in_vec   = gen_stage[s-1].sum_vec;
            assign in_valid = gen_stage[s-1].stage_valid;
        end

        // ==================================================
        // Valid chain
        // ==================================================

        if (s % 2 == 0) begin : gen_valid_reg
            // Pipeline boundary
            always_ff @(posedge clk or negedge rstn) begin
                if (!rstn) begin
                    stage_valid <= 1'b0;
                end else begin
                    stage_valid <= in_valid;
                end
            end
        end else begin : gen_valid_comb
            assign stage_valid = in_valid;
        end

        // ==================================================
        // Adders
        // ==================================================

        for (genvar j = 0; j < OUT_NUM; j++) begin : gen_pair

            logic signed [IN_BIT-1:0]  opnd_a;
            logic signed [IN_BIT-1:0]  opnd_b;
            logic signed [OUT_BIT-1:0] pair_sum;

            if (s % 2 == 0) begin : gen_opnd_reg
                // Capture only when the incoming word is valid
                always_ff @(posedge clk or negedge rstn) begin
                    if (!rstn) begin
                        opnd_a <= '0;
                        opnd_b <= '0;
                    end else if (in_valid) begin
                        opnd_a <= in_vec[(2*j)*IN_BIT +: IN_BIT];
                        opnd_b <= in_vec[(2*j+1)*IN_BIT +: IN_BIT];
                    end
                end
            end else begin : gen_opnd_comb
                assign opnd_a = in_vec[(2*j)*IN_BIT +: IN_BIT];
                assign opnd_b = in_vec[(2*j+1)*IN_BIT +: IN_BIT];
            end

            // Widen before adding so the carry is kept
            assign pair_sum = OUT_BIT'(opnd_a) + OUT_BIT'(opnd_b);

            assign sum_vec[j*OUT_BIT +: OUT_BIT] = pair_sum;

        end

    end

    // ==================================================
    // Output
    // ==================================================

    // Last level holds a single sum of SUM_BIT bits
    assign odata       = gen_stage[STAGE_NUM-1].sum_vec;
    assign odata_valid = gen_stage[STAGE_NUM-1].stage_valid;

endmodule

`default_nettype wire

// ==== hw/mac_core/mul_line.sv ====
`default_nettype none

// ==================================================
// Multiplier line
// ==================================================
// Registers both operand words on idata_valid, then forms
// eight signed 8x8 products from the held lanes.
// The product vector trails the input by one cycle.

module mul_line
    import mac_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rstn,

    // Operand words, one signed lane per byte
    input  wire lane_vec_t idata_a,
    input  wire lane_vec_t idata_b,
    input  wire logic      idata_valid,

    // Packed lane products
    output prod_vec_t      product,
    output logic           product_valid
);

    // ==================================================
    // Per-lane input gating and multiply
    // ==================================================

    for (genvar i = 0; i < MAC_NUM; i++) begin : gen_lane

        // Held operand pair for this lane
        lane_t a_q;
        lane_t b_q;

        // Signed product of the held pair
        prod_t prod;

        // Load only on a valid word, otherwise hold
        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                a_q <= '0;
                b_q <= '0;
            end else if (idata_valid) begin
                a_q <= idata_a[i*IDATA_BIT +: IDATA_BIT];
                b_q <= idata_b[i*IDATA_BIT +: IDATA_BIT];
            end
        end

        // Sign-extend both lanes to the product width first
        // so the low half of the result is the exact product
        assign prod = PROD_BIT'(a_q) * PROD_BIT'(b_q);

        // Lane i lands in slice i of the product vector
        assign product[i*PROD_BIT +: PROD_BIT] = prod;

    end

    // ==================================================
    // Valid strobe
    // ==================================================

    // Follows the lane registers by exactly one cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            product_valid <= 1'b0;
        end else begin
            product_valid <= idata_valid;
        end
    end

endmodule

`default_nettype wire

// ==== common/mac_pkg.sv ====
`default_nettype none

package mac_pkg;

    // ==================================================
    // Sizes
    // ==================================================

    // Data bus width in bits
    localparam int BUS_BIT = 64;

    // Signed input lane width
    localparam int IDATA_BIT = 8;

    // One lane per byte of the bus
    localparam int MAC_NUM = BUS_BIT / IDATA_BIT;

    // Full-precision signed product
    localparam int PROD_BIT = 2 * IDATA_BIT;

    // Adder tree depth
    localparam int STAGE_NUM = $clog2(MAC_NUM);

    // Each tree level adds one bit of growth
    localparam int SUM_BIT = PROD_BIT + STAGE_NUM;

    // ==================================================
    // Latency
    // ==================================================

    // Stage 0 plus every even stage is registered
    localparam int TREE_LAT = (STAGE_NUM + 1) / 2;

    // One cycle in the multiplier line
    localparam int CORE_LAT = 1 + TREE_LAT;

    // ==================================================
    // Types
    // ==================================================

    typedef logic signed [IDATA_BIT-1:0]        lane_t;
    typedef logic        [MAC_NUM*IDATA_BIT-1:0] lane_vec_t;

    typedef logic signed [PROD_BIT-1:0]          prod_t;
    typedef logic        [MAC_NUM*PROD_BIT-1:0]  prod_vec_t;

    // Final dot-product result
    typedef logic signed [SUM_BIT-1:0]           sum_t;

endpackage

`default_nettype wire
